/* verilog/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

	//////////////////////////////////////////////////
	// bus widths and codes
	//////////////////////////////////////////////////

	localparam int unsigned ADDR_W = 32;
	localparam int unsigned DATA_W = 32;
	localparam int unsigned ID_W = 4;

	// read ids, one per requester
	localparam logic [ID_W-1:0] RID_FETCH = 4'd0;
	localparam logic [ID_W-1:0] RID_LOAD_1 = 4'd1;
	localparam logic [ID_W-1:0] RID_LOAD_2 = 4'd2;

	// two beats for an instruction pair
	localparam logic [3:0] FETCH_LEN = 4'd1;
	localparam logic [2:0] SIZE_WORD_AXI = 3'd2;

	// lane side access sizes
	localparam logic [1:0] ACC_BYTE = 2'd1;
	localparam logic [1:0] ACC_HALF = 2'd2;
	localparam logic [1:0] ACC_WORD = 2'd3;

	//////////////////////////////////////////////////
	// structs
	//////////////////////////////////////////////////

	typedef struct packed {
		logic              load;
		logic              store;
		logic [1:0]        size;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} lane_req_t;

	// load/store flags here mean pending
	typedef struct packed {
		logic              fetch;
		logic [ADDR_W-1:0] fetch_pc;
		lane_req_t         lane1;
		lane_req_t         lane2;
	} pend_t;

	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [3:0]        len;
		logic [2:0]        size;
	} ar_t;

	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [DATA_W-1:0] data;
		logic              last;
	} r_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [3:0]        strb;
		logic              last;
	} w_t;

	typedef struct packed {
		logic [DATA_W-1:0] inst_1;
		logic [DATA_W-1:0] inst_2;
	} inst_pair_t;

endpackage

`default_nettype wire

/* verilog/lane_request_latch.sv */
`timescale 1ns/100ps
`default_nettype none

module lane_request_latch (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             fetch_req,
	input  logic [mem_bus_pkg::ADDR_W-1:0]   fetch_pc,
	input  mem_bus_pkg::lane_req_t           lane1_req,
	input  mem_bus_pkg::lane_req_t           lane2_req,
	input  logic                             inst_valid,
	input  logic                             load_done_1,
	input  logic                             load_done_2,
	input  logic                             store_done_1,
	input  logic                             store_done_2,
	input  logic                             fwd_hit,
	output mem_bus_pkg::pend_t               pend,
	output logic                             stall
);

	mem_bus_pkg::lane_req_t lane_in [2];
	mem_bus_pkg::lane_req_t slot [2];
	logic [mem_bus_pkg::ADDR_W-1:0] pc_q;
	logic fetch_pend;
	logic [1:0] ld_pend;
	logic [1:0] st_pend;
	logic [1:0] ld_clr;
	logic [1:0] st_clr;

	assign lane_in[0] = lane1_req;
	assign lane_in[1] = lane2_req;

	// a forwarded lane 2 load never sees a bus beat
	assign ld_clr = {load_done_2 | fwd_hit, load_done_1};
	assign st_clr = {store_done_2, store_done_1};

	//////////////////////////////////////////////////
	// pending flags
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			fetch_pend <= 1'b0;
			ld_pend <= 2'b00;
			st_pend <= 2'b00;
		end
		else
		begin
			if (fetch_req)
				fetch_pend <= 1'b1;
			else if (inst_valid)
				fetch_pend <= 1'b0;
			for (int i = 0; i < 2; i++)
			begin
				if (lane_in[i].load)
					ld_pend[i] <= 1'b1;
				else if (ld_clr[i])
					ld_pend[i] <= 1'b0;
				if (lane_in[i].store)
					st_pend[i] <= 1'b1;
				else if (st_clr[i])
					st_pend[i] <= 1'b0;
			end
		end
	end

	// address, size and data ride along with the flag
	always_ff @(posedge clk)
	begin
		if (fetch_req)
			pc_q <= fetch_pc;
		for (int i = 0; i < 2; i++)
		begin
			if (lane_in[i].load || lane_in[i].store)
				slot[i] <= lane_in[i];
		end
	end

	always_comb
	begin
		pend.fetch = fetch_pend;
		pend.fetch_pc = pc_q;
		pend.lane1 = slot[0];
		pend.lane1.load = ld_pend[0];
		pend.lane1.store = st_pend[0];
		pend.lane2 = slot[1];
		pend.lane2.load = ld_pend[1];
		pend.lane2.store = st_pend[1];
	end

	assign stall = fetch_pend | (|ld_pend) | (|st_pend);

	// pipeline holds off while stalled, so a busy slot is never re-requested
	a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
		!(fetch_req && fetch_pend) &&
		!((lane1_req.load && ld_pend[0]) || (lane1_req.store && st_pend[0])) &&
		!((lane2_req.load && ld_pend[1]) || (lane2_req.store && st_pend[1])));

endmodule

`default_nettype wire

/* verilog/bus_request_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_request_arbiter (
	input  logic                           clk,
	input  logic                           rst_n,
	input  mem_bus_pkg::pend_t             pend,
	input  logic                           arready,
	input  logic                           awready,
	input  logic                           wready,
	output mem_bus_pkg::ar_t               ar,
	output logic                           arvalid,
	output logic [mem_bus_pkg::ADDR_W-1:0] aw_addr,
	output logic                           awvalid,
	output mem_bus_pkg::w_t                w,
	output logic                           wvalid,
	output logic                           store_done_1,
	output logic                           store_done_2,
	output logic                           fwd_hit
);

	logic iss_fetch;
	logic iss_ld1;
	logic iss_ld2;
	logic iss_st1;
	logic iss_st2;
	logic wr_busy;
	logic wr_lane2;
	logic want_fetch;
	logic want_ld1;
	logic want_ld2;
	logic want_st1;
	logic want_st2;
	logic fwd_match;
	logic fwd_go;
	logic rd_go;
	logic wr_go;

	// byte lanes from access size and low address bits
	function automatic logic [3:0] strb_of(input logic [1:0] size, input logic [1:0] a);
		case (size)
			mem_bus_pkg::ACC_BYTE: strb_of = 4'b0001 << a;
			mem_bus_pkg::ACC_HALF: strb_of = a[1] ? 4'b1100 : 4'b0011;
			mem_bus_pkg::ACC_WORD: strb_of = 4'b1111;
			default: strb_of = 4'b1111;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// request selection
	//////////////////////////////////////////////////

	// lane 2 reads what lane 1 is about to write
	assign fwd_match = pend.lane2.load && pend.lane1.store &&
		(pend.lane2.addr == pend.lane1.addr);
	assign fwd_go = pend.lane2.load && !iss_ld2 && fwd_match;

	assign want_fetch = pend.fetch && !iss_fetch;
	assign want_ld1 = pend.lane1.load && !iss_ld1;
	assign want_ld2 = pend.lane2.load && !iss_ld2 && !fwd_match;
	// gap after each pulse keeps arvalid one cycle wide
	assign rd_go = arready && !arvalid && (want_fetch || want_ld1 || want_ld2);

	assign want_st1 = pend.lane1.store && !iss_st1;
	assign want_st2 = pend.lane2.store && !iss_st2;
	assign wr_go = awready && !wr_busy && (want_st1 || want_st2);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			wr_busy <= 1'b0;
			wr_lane2 <= 1'b0;
			fwd_hit <= 1'b0;
			store_done_1 <= 1'b0;
			store_done_2 <= 1'b0;
			iss_fetch <= 1'b0;
			iss_ld1 <= 1'b0;
			iss_ld2 <= 1'b0;
			iss_st1 <= 1'b0;
			iss_st2 <= 1'b0;
		end
		else
		begin
			arvalid <= rd_go;
			awvalid <= wr_go;
			fwd_hit <= fwd_go;
			store_done_1 <= wvalid && wready && !wr_lane2;
			store_done_2 <= wvalid && wready && wr_lane2;
			// issued marks drop once the latch retires the slot
			iss_fetch <= pend.fetch && (iss_fetch || (rd_go && want_fetch));
			iss_ld1 <= pend.lane1.load && (iss_ld1 || (rd_go && !want_fetch && want_ld1));
			iss_ld2 <= pend.lane2.load &&
				(iss_ld2 || fwd_go || (rd_go && !want_fetch && !want_ld1));
			iss_st1 <= pend.lane1.store && (iss_st1 || (wr_go && want_st1));
			iss_st2 <= pend.lane2.store && (iss_st2 || (wr_go && !want_st1));
			if (wr_go)
			begin
				wr_busy <= 1'b1;
				wr_lane2 <= !want_st1;
			end
			else if (wvalid && wready)
				wr_busy <= 1'b0;
			// data beat follows the address pulse and holds until wready
			if (awvalid)
				wvalid <= 1'b1;
			else if (wready)
				wvalid <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// request payload
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rd_go)
		begin
			ar.size <= mem_bus_pkg::SIZE_WORD_AXI;
			if (want_fetch)
			begin
				ar.id <= mem_bus_pkg::RID_FETCH;
				ar.addr <= pend.fetch_pc;
				ar.len <= mem_bus_pkg::FETCH_LEN;
			end
			else if (want_ld1)
			begin
				ar.id <= mem_bus_pkg::RID_LOAD_1;
				ar.addr <= pend.lane1.addr;
				ar.len <= 4'd0;
			end
			else
			begin
				ar.id <= mem_bus_pkg::RID_LOAD_2;
				ar.addr <= pend.lane2.addr;
				ar.len <= 4'd0;
			end
		end
		if (wr_go)
		begin
			w.last <= 1'b1;
			if (want_st1)
			begin
				aw_addr <= pend.lane1.addr;
				w.data <= pend.lane1.wdata;
				w.strb <= strb_of(pend.lane1.size, pend.lane1.addr[1:0]);
			end
			else
			begin
				aw_addr <= pend.lane2.addr;
				w.data <= pend.lane2.wdata;
				w.strb <= strb_of(pend.lane2.size, pend.lane2.addr[1:0]);
			end
		end
	end

	a_strb_set: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid |-> (w.strb != 4'b0000));
	a_ar_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid |=> !arvalid);
	a_aw_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid |=> !awvalid);

endmodule

`default_nettype wire

/* verilog/read_return_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module read_return_buffer (
	input  logic                           clk,
	input  logic                           rst_n,
	input  mem_bus_pkg::r_t                r,
	input  logic                           rvalid,
	input  logic                           fwd_hit,
	input  mem_bus_pkg::pend_t             pend,
	output mem_bus_pkg::inst_pair_t        inst_pair,
	output logic                           inst_valid,
	output logic [mem_bus_pkg::DATA_W-1:0] load_data_1,
	output logic [mem_bus_pkg::DATA_W-1:0] load_data_2,
	output logic                           load_done_1,
	output logic                           load_done_2
);

	logic beat2;
	logic is_fetch;
	logic is_ld1;
	logic is_ld2;

	assign is_fetch = rvalid && (r.id == mem_bus_pkg::RID_FETCH);
	assign is_ld1 = rvalid && (r.id == mem_bus_pkg::RID_LOAD_1);
	assign is_ld2 = rvalid && (r.id == mem_bus_pkg::RID_LOAD_2);

	//////////////////////////////////////////////////
	// completion pulses
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			beat2 <= 1'b0;
			inst_valid <= 1'b0;
			load_done_1 <= 1'b0;
			load_done_2 <= 1'b0;
		end
		else
		begin
			inst_valid <= is_fetch && r.last;
			load_done_1 <= is_ld1;
			load_done_2 <= is_ld2 || fwd_hit;
			// toggle per fetch beat, realigned by last
			if (is_fetch)
				beat2 <= r.last ? 1'b0 : !beat2;
		end
	end

	//////////////////////////////////////////////////
	// data capture
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (is_fetch)
		begin
			if (beat2)
				inst_pair.inst_2 <= r.data;
			else
				inst_pair.inst_1 <= r.data;
		end
		if (is_ld1)
			load_data_1 <= r.data;
		// store data stands in for the bus word
		if (fwd_hit)
			load_data_2 <= pend.lane1.wdata;
		else if (is_ld2)
			load_data_2 <= r.data;
	end

	a_known_id: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid |-> (r.id <= mem_bus_pkg::RID_LOAD_2));

endmodule

`default_nettype wire

/* verilog/mem_bus_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_bus_bridge (
	input  logic                           clk,
	input  logic                           rst_n,
	// lane side
	input  logic                           fetch_req,
	input  logic [mem_bus_pkg::ADDR_W-1:0] fetch_pc,
	input  mem_bus_pkg::lane_req_t         lane1_req,
	input  mem_bus_pkg::lane_req_t         lane2_req,
	output mem_bus_pkg::inst_pair_t        inst_pair,
	output logic                           inst_valid,
	output logic [mem_bus_pkg::DATA_W-1:0] load_data_1,
	output logic [mem_bus_pkg::DATA_W-1:0] load_data_2,
	output logic                           load_done_1,
	output logic                           load_done_2,
	output logic                           store_done_1,
	output logic                           store_done_2,
	output logic                           stall,
	// read channels
	output mem_bus_pkg::ar_t               ar,
	output logic                           arvalid,
	input  logic                           arready,
	input  mem_bus_pkg::r_t                r,
	input  logic                           rvalid,
	// write channels
	output logic [mem_bus_pkg::ADDR_W-1:0] aw_addr,
	output logic                           awvalid,
	input  logic                           awready,
	output mem_bus_pkg::w_t                w,
	output logic                           wvalid,
	input  logic                           wready
);

	mem_bus_pkg::pend_t pend;
	logic fwd_hit;

	lane_request_latch u_latch (
		.clk          (clk),
		.rst_n        (rst_n),
		.fetch_req    (fetch_req),
		.fetch_pc     (fetch_pc),
		.lane1_req    (lane1_req),
		.lane2_req    (lane2_req),
		.inst_valid   (inst_valid),
		.load_done_1  (load_done_1),
		.load_done_2  (load_done_2),
		.store_done_1 (store_done_1),
		.store_done_2 (store_done_2),
		.fwd_hit      (fwd_hit),
		.pend         (pend),
		.stall        (stall)
	);

	bus_request_arbiter u_arbiter (
		.clk          (clk),
		.rst_n        (rst_n),
		.pend         (pend),
		.arready      (arready),
		.awready      (awready),
		.wready       (wready),
		.ar           (ar),
		.arvalid      (arvalid),
		.aw_addr      (aw_addr),
		.awvalid      (awvalid),
		.w            (w),
		.wvalid       (wvalid),
		.store_done_1 (store_done_1),
		.store_done_2 (store_done_2),
		.fwd_hit      (fwd_hit)
	);

	// read beats and forwarded words back to the lanes
	read_return_buffer u_return (
		.clk         (clk),
		.rst_n       (rst_n),
		.r           (r),
		.rvalid      (rvalid),
		.fwd_hit     (fwd_hit),
		.pend        (pend),
		.inst_pair   (inst_pair),
		.inst_valid  (inst_valid),
		.load_data_1 (load_data_1),
		.load_data_2 (load_data_2),
		.load_done_1 (load_done_1),
		.load_done_2 (load_done_2)
	);

endmodule

`default_nettype wire

/* testbench/axi_slave_model.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_slave_model #(
	parameter logic [31:0] SEED = 32'h0
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  mem_bus_pkg::ar_t               ar,
	input  logic                           arvalid,
	output logic                           arready,
	output mem_bus_pkg::r_t                r,
	output logic                           rvalid,
	input  logic [mem_bus_pkg::ADDR_W-1:0] aw_addr,
	input  logic                           awvalid,
	output logic                           awready,
	input  mem_bus_pkg::w_t                w,
	input  logic                           wvalid,
	output logic                           wready
);

	logic [31:0] mem [256];
	mem_bus_pkg::ar_t rd_q [$];
	mem_bus_pkg::ar_t head;
	logic [3:0] beat;
	logic [7:0] wr_idx;
	logic [7:0] rd_idx;
	logic [31:0] rnd;
	integer seed;

	// every byte of the word follows the word index
	function automatic logic [31:0] fill_word(input logic [7:0] idx);
		return {idx ^ 8'hc3, ~idx, idx + 8'h17, {idx[3:0], idx[7:4]}};
	endfunction

	initial
	begin
		seed = SEED;
		for (int i = 0; i < 256; i++)
			mem[i] = fill_word(8'(i));
		arready = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		rvalid = 1'b0;
		r = '0;
		beat = 4'd0;
		wr_idx = 8'd0;
		forever
		begin
			@(negedge clk);
			if (!rst_n)
			begin
				rd_q.delete();
				beat = 4'd0;
				arready = 1'b0;
				awready = 1'b0;
				wready = 1'b0;
				rvalid = 1'b0;
			end
			else
			begin
				if (arvalid)
					rd_q.push_back(ar);
				if (awvalid)
					wr_idx = aw_addr[9:2];
				rnd = $random(seed);
				rvalid = 1'b0;
				if (rd_q.size() != 0 && rnd[7:6] != 2'b00)
				begin
					head = rd_q[0];
					rd_idx = head.addr[9:2] + {4'd0, beat};
					r.id = head.id;
					r.data = mem[rd_idx];
					r.last = (beat == head.len);
					rvalid = 1'b1;
					if (r.last)
					begin
						rd_q.delete(0);
						beat = 4'd0;
					end
					else
						beat = beat + 4'd1;
				end
				// random back-pressure, ready about three cycles in four
				arready = (rnd[1:0] != 2'b00);
				awready = (rnd[3:2] != 2'b00);
				wready = (rnd[5:4] != 2'b00);
				// handshake lands on the coming rising edge
				if (wvalid && wready)
				begin
					for (int b = 0; b < 4; b++)
					begin
						if (w.strb[b])
							mem[wr_idx][8*b +: 8] = w.data[8*b +: 8];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_mem_bus_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_bus_bridge;

	localparam int CLK_PERIOD = 20;
	localparam int OP_TIMEOUT = 200;
	localparam int RANDOM_OPS = 300;
	localparam logic [31:0] SEED = 32'h6622_9b5d;

	logic clk;
	logic rst_n;
	logic fetch_req;
	logic [31:0] fetch_pc;
	mem_bus_pkg::lane_req_t lane1_req;
	mem_bus_pkg::lane_req_t lane2_req;
	mem_bus_pkg::inst_pair_t inst_pair;
	logic inst_valid;
	logic [31:0] load_data_1;
	logic [31:0] load_data_2;
	logic load_done_1;
	logic load_done_2;
	logic store_done_1;
	logic store_done_2;
	logic stall;
	mem_bus_pkg::ar_t ar;
	logic arvalid;
	logic arready;
	mem_bus_pkg::r_t r;
	logic rvalid;
	logic [31:0] aw_addr;
	logic awvalid;
	logic awready;
	mem_bus_pkg::w_t w;
	logic wvalid;
	logic wready;

	logic [31:0] model_mem [256];
	integer seed;

	mem_bus_bridge uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.fetch_req    (fetch_req),
		.fetch_pc     (fetch_pc),
		.lane1_req    (lane1_req),
		.lane2_req    (lane2_req),
		.inst_pair    (inst_pair),
		.inst_valid   (inst_valid),
		.load_data_1  (load_data_1),
		.load_data_2  (load_data_2),
		.load_done_1  (load_done_1),
		.load_done_2  (load_done_2),
		.store_done_1 (store_done_1),
		.store_done_2 (store_done_2),
		.stall        (stall),
		.ar           (ar),
		.arvalid      (arvalid),
		.arready      (arready),
		.r            (r),
		.rvalid       (rvalid),
		.aw_addr      (aw_addr),
		.awvalid      (awvalid),
		.awready      (awready),
		.w            (w),
		.wvalid       (wvalid),
		.wready       (wready)
	);

	axi_slave_model #(.SEED(SEED)) u_slave (
		.clk     (clk),
		.rst_n   (rst_n),
		.ar      (ar),
		.arvalid (arvalid),
		.arready (arready),
		.r       (r),
		.rvalid  (rvalid),
		.aw_addr (aw_addr),
		.awvalid (awvalid),
		.awready (awready),
		.w       (w),
		.wvalid  (wvalid),
		.wready  (wready)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// model and checks
	//////////////////////////////////////////////////

	// same start contents as the slave memory
	function automatic logic [31:0] fill_word(input logic [7:0] idx);
		return {idx ^ 8'hc3, ~idx, idx + 8'h17, {idx[3:0], idx[7:4]}};
	endfunction

	function automatic logic [3:0] byte_enables(input logic [1:0] size, input logic [1:0] lo);
		logic [3:0] be;
		if (size == mem_bus_pkg::ACC_BYTE)
			be = 4'b0001 << lo;
		else if (size == mem_bus_pkg::ACC_HALF)
			be = lo[1] ? 4'b1100 : 4'b0011;
		else
			be = 4'b1111;
		return be;
	endfunction

	function automatic mem_bus_pkg::lane_req_t make_req(
		input logic ld,
		input logic st,
		input logic [1:0] size,
		input logic [31:0] addr,
		input logic [31:0] wdata
	);
		mem_bus_pkg::lane_req_t q;
		q.load = ld;
		q.store = st;
		q.size = size;
		q.addr = addr;
		q.wdata = wdata;
		return q;
	endfunction

	task automatic apply_store(input mem_bus_pkg::lane_req_t q);
		logic [3:0] be;
		logic [7:0] idx;
		be = byte_enables(q.size, q.addr[1:0]);
		idx = q.addr[9:2];
		for (int b = 0; b < 4; b++)
		begin
			if (be[b])
				model_mem[idx][8*b +: 8] = q.wdata[8*b +: 8];
		end
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			stop_run($sformatf("[FAIL] t=%0t %s got %h expected %h",
				$time, name, got, expected));
	endtask

	//////////////////////////////////////////////////
	// one batch of requests, run to completion
	//////////////////////////////////////////////////

	task automatic issue_and_check(input logic do_fetch, input logic [31:0] pc,
		input mem_bus_pkg::lane_req_t q1, input mem_bus_pkg::lane_req_t q2);
		logic [4:0] expect_mask;
		logic [4:0] seen;
		logic [4:0] pulses;
		logic fwd;
		logic [31:0] exp_inst_1;
		logic [31:0] exp_inst_2;
		logic [31:0] exp_ld1;
		logic [31:0] exp_ld2;
		int cycles;
		fwd = q2.load && q1.store && (q2.addr == q1.addr);
		exp_inst_1 = model_mem[pc[9:2]];
		exp_inst_2 = model_mem[pc[9:2] + 8'd1];
		exp_ld1 = model_mem[q1.addr[9:2]];
		exp_ld2 = fwd ? q1.wdata : model_mem[q2.addr[9:2]];
		// lane 1 reaches the bus first
		if (q1.store)
			apply_store(q1);
		if (q2.store)
			apply_store(q2);
		expect_mask = {do_fetch, q1.load, q2.load, q1.store, q2.store};
		fetch_req = do_fetch;
		fetch_pc = pc;
		lane1_req = q1;
		lane2_req = q2;
		seen = 5'b0;
		cycles = 0;
		while (seen != expect_mask)
		begin
			@(negedge clk);
			fetch_req = 1'b0;
			lane1_req.load = 1'b0;
			lane1_req.store = 1'b0;
			lane2_req.load = 1'b0;
			lane2_req.store = 1'b0;
			cycles++;
			if (cycles > OP_TIMEOUT)
				stop_run("timeout: requests still pending after the cycle limit");
			check_value("stall", 32'(stall), 32'd1);
			if (fwd && arvalid && ar.id == mem_bus_pkg::RID_LOAD_2)
				stop_run("a forwarded lane 2 load was sent to the bus");
			// every read beat is one word wide, every write a single last beat
			if (arvalid)
				check_value("ar.size", 32'(ar.size), 32'(mem_bus_pkg::SIZE_WORD_AXI));
			if (wvalid)
				check_value("w.last", 32'(w.last), 32'd1);
			pulses = {inst_valid, load_done_1, load_done_2, store_done_1, store_done_2};
			if ((pulses & ~expect_mask) != 5'b0 || (pulses & seen) != 5'b0)
				stop_run("a completion pulse came for a request that was not pending");
			if (inst_valid)
			begin
				check_value("inst_pair.inst_1", inst_pair.inst_1, exp_inst_1);
				check_value("inst_pair.inst_2", inst_pair.inst_2, exp_inst_2);
			end
			if (load_done_1)
				check_value("load_data_1", load_data_1, exp_ld1);
			if (load_done_2)
				check_value("load_data_2", load_data_2, exp_ld2);
			seen = seen | pulses;
		end
		// stall drops one edge after the last completion
		@(negedge clk);
		check_value("stall", 32'(stall), 32'd0);
	endtask

	task automatic random_op(input logic force_fwd);
		logic [31:0] rnd;
		logic [31:0] pc_rnd;
		logic [31:0] data1;
		logic [31:0] data2;
		logic [1:0] k1;
		logic [1:0] k2;
		logic do_fetch;
		logic do_fwd;
		logic has_store;
		logic [7:0] pc_idx;
		logic [31:0] ld1_addr;
		logic [31:0] ld2_addr;
		logic [31:0] st1_addr;
		logic [31:0] st2_addr;
		mem_bus_pkg::lane_req_t q1;
		mem_bus_pkg::lane_req_t q2;
		rnd = $random(seed);
		pc_rnd = $random(seed);
		data1 = $random(seed);
		data2 = $random(seed);
		// lane 1: 0 idle, 1 load, 2-3 store; lane 2: 0 idle, 1-2 load, 3 store
		k1 = rnd[1:0];
		k2 = rnd[3:2];
		do_fetch = rnd[4];
		do_fwd = force_fwd || (rnd[7:5] == 3'd0);
		if (do_fwd)
		begin
			k1 = 2'd2;
			k2 = 2'd1;
		end
		if (k1 == 2'd0 && k2 == 2'd0)
			do_fetch = 1'b1;
		has_store = k1[1] || (k2 == 2'd3);
		// stores go to the upper half, reads to the lower half, when both occur
		pc_idx = has_store ? {1'b0, pc_rnd[5:0], 1'b0} : pc_rnd[7:0];
		ld1_addr = {22'd0, has_store ? {1'b0, rnd[14:8]} : rnd[15:8], 2'b00};
		ld2_addr = {22'd0, has_store ? {1'b0, rnd[22:16]} : rnd[23:16], 2'b00};
		st1_addr = {22'd0, 1'b1, rnd[14:8], rnd[25:24]};
		st2_addr = {22'd0, 1'b1, rnd[22:16], rnd[27:26]};
		q1 = make_req(k1 == 2'd1, k1[1], rnd[29:28], k1[1] ? st1_addr : ld1_addr, data1);
		q2 = make_req(k2 == 2'd1 || k2 == 2'd2, k2 == 2'd3, rnd[31:30],
			do_fwd ? st1_addr : ((k2 == 2'd3) ? st2_addr : ld2_addr), data2);
		issue_and_check(do_fetch, {22'd0, pc_idx, 2'b00}, q1, q2);
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial
	begin
		seed = SEED;
		rst_n = 1'b0;
		fetch_req = 1'b0;
		fetch_pc = 32'd0;
		lane1_req = '0;
		lane2_req = '0;
		for (int i = 0; i < 256; i++)
			model_mem[i] = fill_word(8'(i));
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		check_value("stall", 32'(stall), 32'd0);
		check_value("arvalid", 32'(arvalid), 32'd0);
		check_value("awvalid", 32'(awvalid), 32'd0);
		check_value("wvalid", 32'(wvalid), 32'd0);
		check_value("inst_valid", 32'(inst_valid), 32'd0);
		check_value("load_done_1", 32'(load_done_1), 32'd0);
		check_value("load_done_2", 32'(load_done_2), 32'd0);
		check_value("store_done_1", 32'(store_done_1), 32'd0);
		check_value("store_done_2", 32'(store_done_2), 32'd0);

		// instruction pair, then one load per lane
		issue_and_check(1'b1, 32'h0000_0040, '0, '0);
		issue_and_check(1'b0, 32'd0,
			make_req(1'b1, 1'b0, mem_bus_pkg::ACC_WORD, 32'h0000_0100, 32'd0),
			make_req(1'b1, 1'b0, mem_bus_pkg::ACC_WORD, 32'h0000_0204, 32'd0));

		// byte and half stores, read back through loads
		issue_and_check(1'b0, 32'd0,
			make_req(1'b0, 1'b1, mem_bus_pkg::ACC_BYTE, 32'h0000_0301, 32'ha1b2_c3d4),
			make_req(1'b0, 1'b1, mem_bus_pkg::ACC_HALF, 32'h0000_03f6, 32'h5566_7788));
		issue_and_check(1'b0, 32'd0,
			make_req(1'b1, 1'b0, mem_bus_pkg::ACC_WORD, 32'h0000_0300, 32'd0),
			make_req(1'b1, 1'b0, mem_bus_pkg::ACC_WORD, 32'h0000_03f4, 32'd0));

		// lane 2 load picks up the lane 1 store data
		issue_and_check(1'b0, 32'd0,
			make_req(1'b0, 1'b1, mem_bus_pkg::ACC_WORD, 32'h0000_0380, 32'h1234_5678),
			make_req(1'b1, 1'b0, mem_bus_pkg::ACC_WORD, 32'h0000_0380, 32'd0));
		random_op(1'b1);

		for (int n = 0; n < RANDOM_OPS; n++)
			random_op(1'b0);

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
verilog/mem_bus_pkg.sv
verilog/lane_request_latch.sv
verilog/bus_request_arbiter.sv
verilog/read_return_buffer.sv
verilog/mem_bus_bridge.sv
testbench/axi_slave_model.sv
testbench/tb_mem_bus_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_mem_bus_bridge -f all.f

output="$(./obj_dir/Vtb_mem_bus_bridge 2>&1 || true)"
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'PASS: all tests'; then
	exit 0
fi
echo "simulation did not report a pass"
exit 1
